//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = icache_mem_tb
FILELIST  = vlog.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = TEST RESULT: PASS
SOURCES   = $(wildcard design/*.sv design/*.svh sim/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, search the log for a pass"
	@echo "  clean  remove the build directory and the log"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/icache_ctrl.sv
/*
 * instruction cache controller
 * tag compare for the fetch address, miss request to the memory bus,
 * tracking of the one outstanding tag and the fill of the returned block
 */

`timescale 1ns/100ps

`include "mem_consts.svh"

module icache_ctrl (
	input  logic                   clock,
	input  logic                   rst_n,

	// fetch side
	input  mem_pkg::fetch_addr_t   fetch_addr,
	output mem_pkg::mem_block_t    fetch_data,
	output logic                   fetch_valid,

	// line store read
	output logic [`IC_INDEX_W-1:0] rd_index,
	input  mem_pkg::mem_block_t    rd_data,
	input  logic [`IC_TAG_W-1:0]   rd_tag,
	input  logic                   rd_valid,

	// line store fill
	output logic                   fill_en,
	output logic [`IC_INDEX_W-1:0] fill_index,
	output logic [`IC_TAG_W-1:0]   fill_tag,

	// request into the arbiter
	output mem_pkg::bus_command_t  icache_command,
	output logic [`MEM_ADDR_W-1:0] icache_addr,
	input  mem_pkg::mem_tag_t      icache_response,
	input  mem_pkg::mem_tag_t      icache_tag
);

	import mem_pkg::*;

	// hit on the current fetch address
	logic                   hit;
	// load driven on the bus this cycle
	logic                   issue;
	// memory took the load this cycle
	logic                   accepted;
	// low in reset and the first cycle after it
	logic                   reset_done;
	// tag of the load in flight, 0 when idle
	mem_tag_t               pending_tag;
	// line the load in flight will fill
	logic [`IC_INDEX_W-1:0] miss_index;
	logic [`IC_TAG_W-1:0]   miss_tag;
	// block-aligned copy of the fetch address
	fetch_addr_t            req_addr;

	////////////////////////////////////////////////////////////
	// lookup
	////////////////////////////////////////////////////////////

	// index field selects the line
	assign rd_index = fetch_addr.fields.index;

	// tag compare against the stored line
	assign hit = rd_valid && (rd_tag == fetch_addr.fields.tag);

	// hit data goes out in the same cycle
	assign fetch_data  = rd_data;
	assign fetch_valid = hit;

	////////////////////////////////////////////////////////////
	// miss request
	////////////////////////////////////////////////////////////

	// bus stays idle until one clock after reset
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			reset_done <= 1'b0;
		end else begin
			reset_done <= 1'b1;
		end
	end

	// clear the byte offset for the bus
	always_comb begin
		req_addr = fetch_addr;
		req_addr.fields.offset = '0;
	end

	assign icache_addr = req_addr.addr;

	// only one load at a time
	// the fill cycle itself still has a pending tag so nothing new goes out
	assign issue = reset_done && !hit && (pending_tag == '0);

	assign icache_command = issue ? BUS_LOAD : BUS_NONE;

	// nonzero response means the memory took it
	assign accepted = issue && (icache_response != '0);

	////////////////////////////////////////////////////////////
	// reply matching and fill
	////////////////////////////////////////////////////////////

	// pending tag never matches 0 so an idle bus tag is ignored
	assign fill_en = (pending_tag != '0) && (icache_tag == pending_tag);

	assign fill_index = miss_index;
	assign fill_tag   = miss_tag;

	// outstanding tag
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			pending_tag <= '0;
		end else if (accepted) begin
			pending_tag <= icache_response;
		end else if (fill_en) begin
			pending_tag <= '0;
		end
	end

	// remember where the block belongs
	// fetch address may move while the load is out
	always_ff @(posedge clock) begin
		if (accepted) begin
			miss_index <= fetch_addr.fields.index;
			miss_tag   <= fetch_addr.fields.tag;
		end
	end

endmodule

//--- design/icache_mem.sv
/*
 * instruction cache line store
 * 32 direct-mapped lines of data, tag and valid
 * one combinational read port, one fill port written on the clock
 */

`timescale 1ns/100ps

`include "mem_consts.svh"

module icache_mem (
	input  logic                   clock,
	input  logic                   rst_n,

	// read port
	input  logic [`IC_INDEX_W-1:0] rd_index,
	output mem_pkg::mem_block_t    rd_data,
	output logic [`IC_TAG_W-1:0]   rd_tag,
	output logic                   rd_valid,

	// fill port
	input  logic                   fill_en,
	input  logic [`IC_INDEX_W-1:0] fill_index,
	input  logic [`IC_TAG_W-1:0]   fill_tag,
	input  mem_pkg::mem_block_t    fill_data
);

	import mem_pkg::*;

	////////////////////////////////////////////////////////////
	// storage
	////////////////////////////////////////////////////////////

	// block payload per line
	mem_block_t             data_array [`IC_LINES];
	// tag per line
	logic [`IC_TAG_W-1:0]   tag_array  [`IC_LINES];
	// one valid bit per line
	logic [`IC_LINES-1:0]   valid_bits;

	// valid bits are the only control state here
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			valid_bits <= '0;
		end else if (fill_en) begin
			valid_bits[fill_index] <= 1'b1;
		end
	end

	// data and tag written together on a fill
	always_ff @(posedge clock) begin
		if (fill_en) begin
			data_array[fill_index] <= fill_data;
			tag_array[fill_index]  <= fill_tag;
		end
	end

	////////////////////////////////////////////////////////////
	// read port
	////////////////////////////////////////////////////////////

	// straight out of the arrays
	// a fill in this cycle shows up next cycle
	always_comb begin
		rd_data  = data_array[rd_index];
		rd_tag   = tag_array[rd_index];
		rd_valid = valid_bits[rd_index];
	end

endmodule

//--- design/icache_mem_top.sv
/*
 * instruction cache and memory arbiter
 * fetch and data ports sharing one tagged memory bus
 */

`timescale 1ns/100ps

`include "mem_consts.svh"

module icache_mem_top (
	input  logic                   clock,
	input  logic                   rst_n,

	// fetch port
	input  mem_pkg::fetch_addr_t   fetch_addr,
	output mem_pkg::mem_block_t    fetch_data,
	output logic                   fetch_valid,

	// data port
	input  mem_pkg::bus_command_t  dcache_command,
	input  logic [`MEM_ADDR_W-1:0] dcache_addr,
	input  logic [1:0]             dcache_size,
	input  mem_pkg::mem_block_t    dcache_data,
	output mem_pkg::mem_tag_t      dcache_response,
	output mem_pkg::mem_tag_t      dcache_tag,
	output mem_pkg::mem_block_t    dcache_data_out,

	// memory bus
	output mem_pkg::bus_command_t  mem_command,
	output logic [`MEM_ADDR_W-1:0] mem_addr,
	output mem_pkg::mem_block_t    mem_data,
	output logic [1:0]             mem_size,
	input  mem_pkg::mem_tag_t      mem_response,
	input  mem_pkg::mem_tag_t      mem_tag,
	input  mem_pkg::mem_block_t    mem_data_in
);

	import mem_pkg::*;

	// controller to line store
	logic [`IC_INDEX_W-1:0] rd_index;
	mem_block_t             rd_data;
	logic [`IC_TAG_W-1:0]   rd_tag;
	logic                   rd_valid;
	logic                   fill_en;
	logic [`IC_INDEX_W-1:0] fill_index;
	logic [`IC_TAG_W-1:0]   fill_tag;

	// controller to arbiter
	bus_command_t           icache_command;
	logic [`MEM_ADDR_W-1:0] icache_addr;
	mem_tag_t               icache_response;
	mem_tag_t               icache_tag;

	////////////////////////////////////////////////////////////
	// instruction cache
	////////////////////////////////////////////////////////////

	icache_ctrl u_icache_ctrl (
		.clock           (clock),
		.rst_n           (rst_n),
		.fetch_addr      (fetch_addr),
		.fetch_data      (fetch_data),
		.fetch_valid     (fetch_valid),
		.rd_index        (rd_index),
		.rd_data         (rd_data),
		.rd_tag          (rd_tag),
		.rd_valid        (rd_valid),
		.fill_en         (fill_en),
		.fill_index      (fill_index),
		.fill_tag        (fill_tag),
		.icache_command  (icache_command),
		.icache_addr     (icache_addr),
		.icache_response (icache_response),
		.icache_tag      (icache_tag)
	);

	// fill data taken straight off the bus
	icache_mem u_icache_mem (
		.clock      (clock),
		.rst_n      (rst_n),
		.rd_index   (rd_index),
		.rd_data    (rd_data),
		.rd_tag     (rd_tag),
		.rd_valid   (rd_valid),
		.fill_en    (fill_en),
		.fill_index (fill_index),
		.fill_tag   (fill_tag),
		.fill_data  (mem_data_in)
	);

	////////////////////////////////////////////////////////////
	// bus sharing
	////////////////////////////////////////////////////////////

	mem_arbiter u_mem_arbiter (
		.icache_command  (icache_command),
		.icache_addr     (icache_addr),
		.icache_response (icache_response),
		.icache_tag      (icache_tag),
		.dcache_command  (dcache_command),
		.dcache_addr     (dcache_addr),
		.dcache_size     (dcache_size),
		.dcache_data     (dcache_data),
		.dcache_response (dcache_response),
		.dcache_tag      (dcache_tag),
		.dcache_data_out (dcache_data_out),
		.mem_command     (mem_command),
		.mem_addr        (mem_addr),
		.mem_data        (mem_data),
		.mem_size        (mem_size),
		.mem_response    (mem_response),
		.mem_tag         (mem_tag),
		.mem_data_in     (mem_data_in)
	);

endmodule

//--- design/mem_arbiter.sv
/*
 * memory bus arbiter
 * data port has priority over instruction fetch
 * responses gated per side, reply tag and data broadcast to both
 */

`timescale 1ns/100ps

`include "mem_consts.svh"

module mem_arbiter (
	// fetch side
	input  mem_pkg::bus_command_t  icache_command,
	input  logic [`MEM_ADDR_W-1:0] icache_addr,
	output mem_pkg::mem_tag_t      icache_response,
	output mem_pkg::mem_tag_t      icache_tag,

	// data side
	input  mem_pkg::bus_command_t  dcache_command,
	input  logic [`MEM_ADDR_W-1:0] dcache_addr,
	input  logic [1:0]             dcache_size,
	input  mem_pkg::mem_block_t    dcache_data,
	output mem_pkg::mem_tag_t      dcache_response,
	output mem_pkg::mem_tag_t      dcache_tag,
	output mem_pkg::mem_block_t    dcache_data_out,

	// memory bus
	output mem_pkg::bus_command_t  mem_command,
	output logic [`MEM_ADDR_W-1:0] mem_addr,
	output mem_pkg::mem_block_t    mem_data,
	output logic [1:0]             mem_size,
	input  mem_pkg::mem_tag_t      mem_response,
	input  mem_pkg::mem_tag_t      mem_tag,
	input  mem_pkg::mem_block_t    mem_data_in
);

	import mem_pkg::*;

	// size code for a whole block
	localparam logic [1:0] SIZE_DOUBLE = 2'h3;

	// data side owns the bus this cycle
	logic data_active;
	// fetch side owns the bus this cycle
	logic fetch_active;

	assign data_active  = (dcache_command != BUS_NONE);
	assign fetch_active = !data_active && (icache_command != BUS_NONE);

	////////////////////////////////////////////////////////////
	// request mux
	////////////////////////////////////////////////////////////

	// fetch carries no store data
	always_comb begin
		if (data_active) begin
			mem_command = dcache_command;
			mem_addr    = dcache_addr;
			mem_data    = dcache_data;
			mem_size    = dcache_size;
		end else begin
			mem_command = icache_command;
			mem_addr    = icache_addr;
			mem_data    = '0;
			mem_size    = SIZE_DOUBLE;
		end
	end

	////////////////////////////////////////////////////////////
	// response routing
	////////////////////////////////////////////////////////////

	// losing side sees 0 and retries
	assign dcache_response = data_active  ? mem_response : '0;
	assign icache_response = fetch_active ? mem_response : '0;

	// replies go to both sides, each matches its own tag
	assign dcache_tag      = mem_tag;
	assign icache_tag      = mem_tag;
	assign dcache_data_out = mem_data_in;

endmodule

//--- design/mem_consts.svh
/*
 * memory subsystem constants
 * address and block widths, instruction cache geometry, bus tag width
 */

`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// byte address on the memory bus
`define MEM_ADDR_W   32

// one memory block is a double word
`define MEM_BLOCK_W  64

// direct-mapped instruction cache
`define IC_LINES     32
`define IC_INDEX_W   5
`define IC_TAG_W     8

// byte offset inside a block
`define IC_OFFSET_W  3

// response and reply tags
// zero is reserved for no tag
`define MEM_TAG_W    4

`endif

//--- design/mem_pkg.sv
/*
 * memory subsystem types
 * bus commands, bus tags, data blocks and the two views of a fetch address
 */

`include "mem_consts.svh"

package mem_pkg;

	// command encoding seen by the memory
	typedef enum logic [1:0] {
		BUS_NONE  = 2'h0,
		BUS_LOAD  = 2'h1,
		BUS_STORE = 2'h2
	} bus_command_t;

	// transaction tag
	// 0 means rejected or nothing returned
	typedef logic [`MEM_TAG_W-1:0] mem_tag_t;

	// one memory block
	typedef logic [`MEM_BLOCK_W-1:0] mem_block_t;

	// fields as the cache sees them
	// top 16 bits are not part of the tag
	typedef struct packed {
		logic [`MEM_ADDR_W-`IC_TAG_W-`IC_INDEX_W-`IC_OFFSET_W-1:0] unused;
		logic [`IC_TAG_W-1:0]    tag;
		logic [`IC_INDEX_W-1:0]  index;
		logic [`IC_OFFSET_W-1:0] offset;
	} fetch_fields_t;

	// flat view goes on the bus, field view feeds the cache
	typedef union packed {
		logic [`MEM_ADDR_W-1:0] addr;
		fetch_fields_t          fields;
	} fetch_addr_t;

endpackage

//--- sim/icache_mem_tb.sv
/*
 * instruction cache and memory arbiter testbench
 * trace-driven fetch, data and reset steps against a tagged memory model
 * memory block at aligned address A is {A, ~A}
 */

`timescale 1ns/100ps

`include "mem_consts.svh"

module icache_mem_tb;

	import mem_pkg::*;

	localparam int          MAX_STEPS        = 32;
	localparam int          RESET_CYCLES     = 8;
	localparam int          WAIT_LIMIT       = 64;
	localparam int          SETTLE           = 25;
	localparam logic [31:0] DATA_OFFSET      = 32'h0010_0000;
	localparam logic [31:0] SEED             = 32'h06ef13ce;
	// size codes, byte to double word
	localparam logic [1:0]  WORD_SIZE        = 2'h2;
	localparam logic [1:0]  DOUBLE_WORD_SIZE = 2'h3;

	logic                   clock;
	logic                   rst_n;
	fetch_addr_t            fetch_addr;
	mem_block_t             fetch_data;
	logic                   fetch_valid;
	bus_command_t           dcache_command;
	logic [`MEM_ADDR_W-1:0] dcache_addr;
	logic [1:0]             dcache_size;
	mem_block_t             dcache_data;
	mem_tag_t               dcache_response;
	mem_tag_t               dcache_tag;
	mem_block_t             dcache_data_out;
	bus_command_t           mem_command;
	logic [`MEM_ADDR_W-1:0] mem_addr;
	mem_block_t             mem_data;
	logic [1:0]             mem_size;
	mem_tag_t               mem_response;
	mem_tag_t               mem_tag;
	mem_block_t             mem_data_in;

	// five words per step, see the trace file
	logic [63:0] trace_mem [0:5*MAX_STEPS-1];

	// memory model state, only touched right after a falling edge
	int          reject_left;
	int          reply_delay;
	int          cycle_no;
	mem_tag_t    next_tag;
	mem_tag_t    reply_tag [$];
	logic [31:0] reply_addr [$];
	int          reply_due [$];

	// bus and port values sampled mid-cycle
	bus_command_t smp_cmd;
	logic [31:0]  smp_addr;
	mem_tag_t     smp_resp;
	logic [1:0]   smp_size;
	mem_block_t   smp_mdata;
	logic         smp_valid;
	mem_block_t   smp_fdata;
	mem_tag_t     smp_dresp;
	mem_tag_t     smp_dtag;
	mem_block_t   smp_ddata;

	int   step_no;
	int   step_errors;
	int   passed;
	int   failed;
	logic timed_out;

	tb_clock_gen u_clock_gen (
		.clock (clock)
	);

	icache_mem_top u_dut (
		.clock           (clock),
		.rst_n           (rst_n),
		.fetch_addr      (fetch_addr),
		.fetch_data      (fetch_data),
		.fetch_valid     (fetch_valid),
		.dcache_command  (dcache_command),
		.dcache_addr     (dcache_addr),
		.dcache_size     (dcache_size),
		.dcache_data     (dcache_data),
		.dcache_response (dcache_response),
		.dcache_tag      (dcache_tag),
		.dcache_data_out (dcache_data_out),
		.mem_command     (mem_command),
		.mem_addr        (mem_addr),
		.mem_data        (mem_data),
		.mem_size        (mem_size),
		.mem_response    (mem_response),
		.mem_tag         (mem_tag),
		.mem_data_in     (mem_data_in)
	);

	// memory takes any command in the same cycle unless told to refuse
	assign mem_response = (rst_n && mem_command != BUS_NONE && reject_left == 0) ?
		next_tag : '0;

	function automatic mem_block_t block_for_addr(input logic [31:0] addr);
		return {addr, ~addr};
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] got,
			input logic [63:0] expected);
		$display("FAILED step %0d %s: got %h expected %h", step_no, name, got, expected);
		step_errors++;
	endtask

	////////////////////////////////////////////////////////////
	// cycle handling
	////////////////////////////////////////////////////////////

	// falling edge: settle last cycle's bus activity, present a due reply
	task automatic begin_cycle;
		@(negedge clock);
		cycle_no++;
		if (smp_cmd != BUS_NONE && smp_resp != '0) begin
			if (smp_cmd == BUS_LOAD) begin
				reply_tag.push_back(smp_resp);
				reply_addr.push_back(smp_addr);
				reply_due.push_back(cycle_no - 1 + reply_delay);
			end
			next_tag = (next_tag == 4'hf) ? 4'h1 : next_tag + 4'h1;
		end else if (smp_cmd != BUS_NONE && reject_left > 0) begin
			reject_left--;
		end
		// in-order replies, one per cycle
		if (reply_due.size() > 0 && reply_due[0] <= cycle_no) begin
			mem_tag     = reply_tag.pop_front();
			mem_data_in = block_for_addr(reply_addr.pop_front());
			void'(reply_due.pop_front());
		end else begin
			mem_tag     = '0;
			mem_data_in = '0;
		end
	endtask

	// sample well before the next rising edge
	task automatic sample_cycle;
		#(SETTLE);
		smp_cmd   = mem_command;
		smp_addr  = mem_addr;
		smp_resp  = mem_response;
		smp_size  = mem_size;
		smp_mdata = mem_data;
		smp_valid = fetch_valid;
		smp_fdata = fetch_data;
		smp_dresp = dcache_response;
		smp_dtag  = dcache_tag;
		smp_ddata = dcache_data_out;
	endtask

	task automatic apply_reset;
		int n;
		for (n = 0; n < RESET_CYCLES; n++) begin
			begin_cycle();
			rst_n          = 1'b0;
			dcache_command = BUS_NONE;
			reply_tag.delete();
			reply_addr.delete();
			reply_due.delete();
			mem_tag        = '0;
			mem_data_in    = '0;
			reject_left    = 0;
			sample_cycle();
		end
		// first cycle out of reset
		begin_cycle();
		rst_n = 1'b1;
		sample_cycle();
	endtask

	////////////////////////////////////////////////////////////
	// steps
	////////////////////////////////////////////////////////////

	task automatic fetch_miss_step(input logic [31:0] addr, input int rejects,
			input int delay, input mem_block_t expected, input logic with_data);
		logic [31:0] line_addr;
		logic [31:0] data_addr;
		mem_tag_t    data_tag;
		logic        data_seen;
		logic        done;
		int          slack;
		int          waited;
		int          refused;
		int          fetch_loads;
		line_addr   = {addr[31:3], 3'b000};
		data_addr   = line_addr + DATA_OFFSET;
		data_tag    = '0;
		data_seen   = !with_data;
		done        = 1'b0;
		waited      = 0;
		refused     = 0;
		fetch_loads = 0;
		// cycles the fetch runs alone before the data load arrives
		slack       = with_data ? int'($urandom % (rejects + 1)) : 0;
		while (!done) begin
			begin_cycle();
			if (waited == 0) begin
				reject_left = rejects;
				reply_delay = delay;
			end
			fetch_addr.addr = addr;
			if (with_data && data_tag == '0 && waited >= slack) begin
				dcache_command = BUS_LOAD;
				dcache_addr    = data_addr;
				dcache_data    = {data_addr, data_addr};
			end else begin
				dcache_command = BUS_NONE;
			end
			sample_cycle();
			if (waited == 0 && smp_valid) begin
				$display("step %0d: fetch_valid was high on an address that should miss", step_no);
				step_errors++;
			end
			// data side owns the bus while it asks
			if (dcache_command != BUS_NONE) begin
				if (smp_cmd != BUS_LOAD)
					report_mismatch("mem_command", {62'h0, smp_cmd}, {62'h0, BUS_LOAD});
				if (smp_addr != data_addr)
					report_mismatch("mem_addr", {32'h0, smp_addr}, {32'h0, data_addr});
				if (smp_size != dcache_size)
					report_mismatch("mem_size", {62'h0, smp_size}, {62'h0, dcache_size});
				if (smp_mdata !== dcache_data)
					report_mismatch("mem_data", smp_mdata, dcache_data);
				if (smp_dresp != smp_resp)
					report_mismatch("dcache_response", {60'h0, smp_dresp}, {60'h0, smp_resp});
				data_tag = smp_dresp;
			end else if (smp_cmd == BUS_LOAD) begin
				if (smp_addr != line_addr)
					report_mismatch("mem_addr", {32'h0, smp_addr}, {32'h0, line_addr});
				if (smp_size != DOUBLE_WORD_SIZE)
					report_mismatch("mem_size", {62'h0, smp_size}, {62'h0, DOUBLE_WORD_SIZE});
				if (smp_resp != '0)
					fetch_loads++;
				else
					refused++;
			end
			if (data_tag != '0 && !data_seen && smp_dtag == data_tag) begin
				if (smp_ddata !== block_for_addr(data_addr))
					report_mismatch("dcache_data_out", smp_ddata, block_for_addr(data_addr));
				data_seen = 1'b1;
			end
			waited++;
			if (smp_valid && data_seen) begin
				done = 1'b1;
			end else if (waited >= WAIT_LIMIT) begin
				$display("step %0d: fetch did not complete within %0d cycles", step_no, waited);
				step_errors++;
				timed_out = 1'b1;
				done      = 1'b1;
			end
		end
		if (!timed_out) begin
			if (smp_fdata !== expected)
				report_mismatch("fetch_data", smp_fdata, expected);
			if (fetch_loads != 1) begin
				$display("step %0d: memory took %0d fetch loads instead of one", step_no, fetch_loads);
				step_errors++;
			end
			if (refused != (with_data ? slack : rejects)) begin
				$display("step %0d: fetch load was repeated %0d times after refusal", step_no, refused);
				step_errors++;
			end
		end
	endtask

	task automatic fetch_hit_step(input logic [31:0] addr, input mem_block_t expected);
		begin_cycle();
		fetch_addr.addr = addr;
		dcache_command  = BUS_NONE;
		sample_cycle();
		if (!smp_valid) begin
			$display("step %0d: fetch_valid stayed low on a cached address", step_no);
			step_errors++;
		end
		if (smp_cmd != BUS_NONE)
			report_mismatch("mem_command", {62'h0, smp_cmd}, {62'h0, BUS_NONE});
		if (smp_fdata !== expected)
			report_mismatch("fetch_data", smp_fdata, expected);
	endtask

	// the held fetch address was cached, it must miss after reset
	task automatic reset_step;
		logic [31:0] line_addr;
		line_addr = {fetch_addr.addr[31:3], 3'b000};
		apply_reset();
		// idle bus and no hit straight out of reset
		if (smp_valid !== 1'b0)
			report_mismatch("fetch_valid", {63'h0, smp_valid}, 64'h0);
		if (smp_cmd != BUS_NONE)
			report_mismatch("mem_command", {62'h0, smp_cmd}, {62'h0, BUS_NONE});
		// next cycle the held address goes out again, refused here
		begin_cycle();
		reject_left = 1;
		sample_cycle();
		if (smp_valid !== 1'b0)
			report_mismatch("fetch_valid", {63'h0, smp_valid}, 64'h0);
		if (smp_cmd != BUS_LOAD)
			report_mismatch("mem_command", {62'h0, smp_cmd}, {62'h0, BUS_LOAD});
		if (smp_addr != line_addr)
			report_mismatch("mem_addr", {32'h0, smp_addr}, {32'h0, line_addr});
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		int          kind;
		int          rejects;
		int          delay;
		logic [31:0] addr;
		mem_block_t  expected;
		rst_n           = 1'b0;
		fetch_addr.addr = '0;
		dcache_command  = BUS_NONE;
		dcache_addr     = '0;
		dcache_size     = WORD_SIZE;
		dcache_data     = '0;
		mem_tag         = '0;
		mem_data_in     = '0;
		reject_left     = 0;
		reply_delay     = 1;
		cycle_no        = 0;
		next_tag        = 4'h1;
		smp_cmd         = BUS_NONE;
		smp_resp        = '0;
		passed          = 0;
		failed          = 0;
		timed_out       = 1'b0;
		void'($urandom(SEED));
		$readmemh("sim/icache_trace.txt", trace_mem);
		step_no = 0;
		apply_reset();
		for (step_no = 0; step_no < MAX_STEPS; step_no++) begin
			kind     = int'(trace_mem[5*step_no][31:0]);
			addr     = trace_mem[5*step_no + 1][31:0];
			rejects  = int'(trace_mem[5*step_no + 2][31:0]);
			delay    = int'(trace_mem[5*step_no + 3][31:0]);
			expected = trace_mem[5*step_no + 4];
			if (kind == 0 || timed_out)
				break;
			step_errors = 0;
			case (kind)
				1: fetch_miss_step(addr, rejects, delay, expected, 1'b0);
				2: fetch_hit_step(addr, expected);
				3: fetch_miss_step(addr, rejects, delay, expected, 1'b1);
				4: reset_step();
				default: begin
					$display("step %0d: unknown step kind %0d in the trace", step_no, kind);
					step_errors++;
				end
			endcase
			if (step_errors == 0) begin
				passed++;
				$display("step %0d kind %0d addr %h: ok", step_no, kind, addr);
			end else begin
				failed++;
				$display("step %0d kind %0d addr %h: %0d errors", step_no, kind, addr, step_errors);
			end
		end
		$display("steps run %0d, passed %0d, failed %0d", passed + failed, passed, failed);
		if (failed == 0 && passed > 0 && !timed_out) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- sim/icache_trace.txt
// kind addr rejects delay expected_block, all hex
// kind 1 fetch miss, 2 fetch hit, 3 fetch miss under a data load, 4 reset, 0 end
1 00001000 0 3 00001000ffffefff
2 00001004 0 0 00001000ffffefff
1 00002000 0 2 00002000ffffdfff
1 00001000 0 4 00001000ffffefff
2 00001000 0 0 00001000ffffefff
3 00003008 2 3 00003008ffffcff7
2 0000300c 0 0 00003008ffffcff7
1 00004010 3 2 00004010ffffbfef
2 00004010 0 0 00004010ffffbfef
4 00000000 0 0 0000000000000000
1 00001000 0 1 00001000ffffefff
2 00001006 0 0 00001000ffffefff
3 00005018 4 5 00005018ffffafe7
1 12342040 1 3 12342040edcbdfbf
2 12342044 0 0 12342040edcbdfbf
0 00000000 0 0 0000000000000000

//--- sim/tb_clock_gen.sv
/*
 * testbench clock source
 * free-running clock, 100 ns period
 */

`timescale 1ns/100ps

module tb_clock_gen #(
	parameter int PERIOD = 100
) (
	output logic clock
);

	// starts low, first rising edge half a period in
	initial clock = 1'b0;

	always #(PERIOD / 2) clock = ~clock;

endmodule

//--- vlog.f
+incdir+design
design/mem_pkg.sv
design/icache_mem.sv
design/icache_ctrl.sv
design/mem_arbiter.sv
design/icache_mem_top.sv
sim/tb_clock_gen.sv
sim/icache_mem_tb.sv
